// ==== design/nete_pkg.sv ====
package nete_pkg;

    //**************************************************************************
    // stream and FIFO geometry
    //**************************************************************************

    // one output beat
    localparam int LANE_W = 64;

    // beats per FIFO word
    localparam int LANES = 4;

    // MAC FIFO word
    localparam int WORD_W = LANES * LANE_W;

    localparam int LANE_BYTES = LANE_W / 8;

    // one keep bit per byte of a beat
    localparam int KEEP_W = LANE_BYTES;

    // byte count field in the header lane
    localparam int BCNT_W = 16;

    // 15 full words less the 8-byte header
    localparam int MAX_PKT_BYTES = 472;

    // enough to count the words of the largest packet
    localparam int WCNT_W = $clog2((MAX_PKT_BYTES + LANE_BYTES) / (WORD_W / 8) + 1);

    //**************************************************************************
    // word layout
    //**************************************************************************

    typedef logic [LANE_W-1:0] lane_t;

    // first word of a packet is read through hdr, every word through lanes
    typedef union packed {
        struct packed {
            // lanes 3..1, payload
            lane_t [LANES-2:0]         payload;
            // upper part of lane 0, unused
            logic  [LANE_W-BCNT_W-1:0] rsvd;
            // payload bytes, header excluded
            logic  [BCNT_W-1:0]        byte_count;
        } hdr;
        // lane 0 in the low bits
        lane_t [LANES-1:0] lanes;
    } mac_word_u;

endpackage

// ==== design/nete_fetch.sv ====
module nete_fetch #(
    parameter int READ_LATENCY = 2
) (
    input  logic                        clk,
    input  logic                        reset_,
    input  nete_pkg::mac_word_u         tx_data_in,
    input  logic                        tx_mac_empty,
    input  logic                        word_done,
    input  logic                        pkt_done,
    output logic                        tx_mac_rd_en,
    output nete_pkg::mac_word_u         word,
    output logic                        word_valid,
    output logic                        first_word,
    output logic [nete_pkg::BCNT_W-1:0] byte_count
);
    import nete_pkg::*;

    localparam int WORD_BYTES = WORD_W / 8;
    // header lane plus rounding up to whole words
    localparam int HDR_ROUND = LANE_BYTES + WORD_BYTES - 1;
    localparam int LAT_W = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

    // fsm encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_READ = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_BUSY = 2'd3;

    logic [1:0]        state;
    logic [LAT_W-1:0]  lat_cnt;
    logic [WCNT_W-1:0] wcnt;
    logic [WCNT_W-1:0] wtotal;
    logic [BCNT_W:0]   hdr_span;
    logic [WCNT_W-1:0] hdr_words;
    logic              lat_done;
    logic              more_words;

    // words per packet, ceil((bytes + 8) / 32)
    assign hdr_span  = {1'b0, tx_data_in.hdr.byte_count} + HDR_ROUND[BCNT_W:0];
    assign hdr_words = WCNT_W'(hdr_span / WORD_BYTES);

    // last wait cycle, FIFO data valid now
    assign lat_done   = (lat_cnt == LAT_W'(READ_LATENCY - 1));
    assign more_words = (wcnt != wtotal);

    //**************************************************************************
    // read control
    //**************************************************************************

    always_ff @(posedge clk) begin
        if (!reset_) begin
            state        <= ST_IDLE;
            tx_mac_rd_en <= 1'b0;
            word_valid   <= 1'b0;
            lat_cnt      <= '0;
            wcnt         <= '0;
        end else begin
            // both are single-cycle strobes
            tx_mac_rd_en <= 1'b0;
            word_valid   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!tx_mac_empty) begin
                        tx_mac_rd_en <= 1'b1;
                        wcnt         <= '0;
                        state        <= ST_READ;
                    end
                end
                // strobe is out this cycle
                ST_READ: begin
                    lat_cnt <= '0;
                    state   <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (lat_done) begin
                        word_valid <= 1'b1;
                        wcnt       <= wcnt + 1'b1;
                        state      <= ST_BUSY;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                // splitter draining the word
                ST_BUSY: begin
                    if (word_done) begin
                        if (!pkt_done && more_words) begin
                            tx_mac_rd_en <= 1'b1;
                            state        <= ST_READ;
                        end else if (!tx_mac_empty) begin
                            // next packet back to back
                            tx_mac_rd_en <= 1'b1;
                            wcnt         <= '0;
                            state        <= ST_READ;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // capture word, header fields only from the first word
    always_ff @(posedge clk) begin
        if (state == ST_WAIT && lat_done) begin
            word       <= tx_data_in;
            first_word <= (wcnt == '0);
            if (wcnt == '0) begin
                byte_count <= tx_data_in.hdr.byte_count;
                wtotal     <= hdr_words;
            end
        end
    end

endmodule

// ==== design/nete_beat_split.sv ====
module nete_beat_split (
    input  logic                        clk,
    input  logic                        reset_,
    input  nete_pkg::mac_word_u         word,
    input  logic                        word_valid,
    input  logic                        first_word,
    input  logic [nete_pkg::BCNT_W-1:0] byte_count,
    output logic                        word_done,
    output logic                        pkt_done,
    output nete_pkg::lane_t             beat_data,
    output logic                        beat_valid,
    output logic [3:0]                  beat_bytes,
    output logic                        beat_last
);
    import nete_pkg::*;

    localparam int IDX_W = $clog2(LANES);

    mac_word_u         word_q;
    logic [IDX_W-1:0]  lane_idx;
    logic [BCNT_W-1:0] bytes_left;
    logic              active;
    logic              tail;
    logic              lane_end;

    //**************************************************************************
    // current beat
    //**************************************************************************

    // 8 bytes or fewer left, this beat ends the packet
    assign tail     = (bytes_left <= BCNT_W'(LANE_BYTES));
    // top lane of the held word
    assign lane_end = (lane_idx == IDX_W'(LANES - 1));

    assign beat_valid = active;
    assign beat_data  = word_q.lanes[lane_idx];
    // partial count only on the tail beat
    assign beat_bytes = tail ? bytes_left[3:0] : 4'(LANE_BYTES);
    assign beat_last  = active && tail;

    // word ends at lane 3 or early at the packet end
    assign word_done = active && (tail || lane_end);
    assign pkt_done  = active && tail;

    //**************************************************************************
    // lane stepping and byte accounting
    //**************************************************************************

    always_ff @(posedge clk) begin
        if (!reset_) begin
            active     <= 1'b0;
            lane_idx   <= '0;
            bytes_left <= '0;
        end else if (word_valid) begin
            active <= 1'b1;
            // lane 0 of a first word is the header
            if (first_word) begin
                lane_idx   <= IDX_W'(1);
                bytes_left <= byte_count;
            end else begin
                lane_idx <= '0;
            end
        end else if (active) begin
            lane_idx <= lane_idx + 1'b1;
            if (tail) begin
                bytes_left <= '0;
            end else begin
                bytes_left <= bytes_left - BCNT_W'(LANE_BYTES);
            end
            // idle until fetch delivers the next word
            if (word_done) begin
                active <= 1'b0;
            end
        end
    end

    // word held for the beats that follow
    always_ff @(posedge clk) begin
        if (word_valid) begin
            word_q <= word;
        end
    end

endmodule

// ==== design/nete_stream_out.sv ====
module nete_stream_out (
    input  logic                        clk,
    input  logic                        reset_,
    input  nete_pkg::lane_t             beat_data,
    input  logic                        beat_valid,
    input  logic [3:0]                  beat_bytes,
    input  logic                        beat_last,
    output nete_pkg::lane_t             tdata,
    output logic                        tvalid,
    output logic [nete_pkg::KEEP_W-1:0] tkeep,
    output logic                        tlast
);
    import nete_pkg::*;

    logic [KEEP_W-1:0] keep_mask;

    // thermometer mask, low beat_bytes bits set
    always_comb begin
        for (int i = 0; i < KEEP_W; i++) begin
            keep_mask[i] = (4'(i) < beat_bytes);
        end
    end

    //**************************************************************************
    // output register
    //**************************************************************************

    always_ff @(posedge clk) begin
        tdata <= beat_data;
    end

    // qualifiers forced low between beats
    always_ff @(posedge clk) begin
        if (!reset_) begin
            tvalid <= 1'b0;
            tkeep  <= '0;
            tlast  <= 1'b0;
        end else begin
            tvalid <= beat_valid;
            tkeep  <= beat_valid ? keep_mask : '0;
            tlast  <= beat_valid && beat_last;
        end
    end

endmodule

// ==== design/nete_tx.sv ====
module nete_tx #(
    parameter int READ_LATENCY = 2
) (
    input  logic                        clk,
    input  logic                        reset_,
    // MAC FIFO side
    input  nete_pkg::mac_word_u         tx_data_in,
    input  logic                        tx_mac_empty,
    output logic                        tx_mac_rd_en,
    // beat stream, no back-pressure
    output nete_pkg::lane_t             tdata,
    output logic                        tvalid,
    output logic [nete_pkg::KEEP_W-1:0] tkeep,
    output logic                        tlast
);
    import nete_pkg::*;

    // fetch to splitter
    mac_word_u         word;
    logic              word_valid;
    logic              first_word;
    logic [BCNT_W-1:0] byte_count;

    // splitter back to fetch
    logic              word_done;
    logic              pkt_done;

    // splitter to output stage
    lane_t             beat_data;
    logic              beat_valid;
    logic [3:0]        beat_bytes;
    logic              beat_last;

    nete_fetch #(
        .READ_LATENCY (READ_LATENCY)
    ) nete_fetch_i (
        .clk          (clk),
        .reset_       (reset_),
        .tx_data_in   (tx_data_in),
        .tx_mac_empty (tx_mac_empty),
        .word_done    (word_done),
        .pkt_done     (pkt_done),
        .tx_mac_rd_en (tx_mac_rd_en),
        .word         (word),
        .word_valid   (word_valid),
        .first_word   (first_word),
        .byte_count   (byte_count)
    );

    nete_beat_split nete_beat_split_i (
        .clk        (clk),
        .reset_     (reset_),
        .word       (word),
        .word_valid (word_valid),
        .first_word (first_word),
        .byte_count (byte_count),
        .word_done  (word_done),
        .pkt_done   (pkt_done),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .beat_bytes (beat_bytes),
        .beat_last  (beat_last)
    );

    nete_stream_out nete_stream_out_i (
        .clk        (clk),
        .reset_     (reset_),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .beat_bytes (beat_bytes),
        .beat_last  (beat_last),
        .tdata      (tdata),
        .tvalid     (tvalid),
        .tkeep      (tkeep),
        .tlast      (tlast)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== test/nete_tx_properties.sv ====
module nete_tx_properties (
    input logic                        clk,
    input logic                        reset_,
    input logic                        tx_mac_rd_en,
    input logic                        tvalid,
    input logic                        tlast,
    input logic [nete_pkg::KEEP_W-1:0] tkeep
);
    timeunit 1ns;
    timeprecision 100ps;

    // read strobe is a single-cycle pulse
    rd_en_pulse: assert property (
        @(posedge clk) disable iff (!reset_) tx_mac_rd_en |=> !tx_mac_rd_en
    ) else $error("tx_mac_rd_en high on two cycles in a row");

    // last only on a valid beat
    last_needs_valid: assert property (
        @(posedge clk) disable iff (!reset_) tlast |-> tvalid
    ) else $error("tlast high while tvalid is low");

    // keep cleared between beats
    keep_idle_zero: assert property (
        @(posedge clk) disable iff (!reset_) !tvalid |-> (tkeep == '0)
    ) else $error("tkeep nonzero while tvalid is low");

endmodule

// ==== test/nete_tx_tb.sv ====
module nete_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import nete_pkg::*;

    localparam int READ_LATENCY   = 2;
    localparam int NUM_PKTS       = 200;
    // longest packet plus an idle gap stays under this
    localparam int CYCLES_PER_PKT = 200;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * CYCLES_PER_PKT;
    localparam int WORD_BYTES     = WORD_W / 8;
    localparam int MAX_WORDS      = (MAX_PKT_BYTES + LANE_BYTES + WORD_BYTES - 1) / WORD_BYTES;
    localparam int DRIVE_DELAY    = 1;
    localparam int unsigned SEED  = 32'hb0b6_b720;

    logic              clk;
    logic              reset_       = 1'b0;
    mac_word_u         tx_data_in   = '0;
    logic              tx_mac_empty = 1'b1;
    logic              tx_mac_rd_en;
    lane_t             tdata;
    logic              tvalid;
    logic [KEEP_W-1:0] tkeep;
    logic              tlast;

    // FIFO model, words tagged with their packet
    logic [WORD_W-1:0] fifo_q[$];
    int                tag_q[$];
    logic [WORD_W-1:0] pend_word;
    int                pend_tag;
    logic              rd_pending = 1'b0;
    int                rd_wait    = 0;
    logic              data_due;

    // expected beats, in stream order
    lane_t             exp_data_q[$];
    logic [KEEP_W-1:0] exp_keep_q[$];
    logic              exp_last_q[$];
    lane_t             exp_data;
    logic [KEEP_W-1:0] exp_keep;
    logic              exp_last;
    lane_t             data_mask;

    int exp_reads[NUM_PKTS] = '{default: 0};
    int got_reads[NUM_PKTS] = '{default: 0};
    int fixed_lens[5]       = '{1, 24, 25, 32, MAX_PKT_BYTES};

    int          cycle_count    = 0;
    int          pkts_seen      = 0;
    logic        idle_expected  = 1'b0;
    int          out_mismatches = 0;
    int          out_faults     = 0;
    int          fifo_faults    = 0;
    int          end_mismatches = 0;
    int          end_faults     = 0;
    int          nbytes;

    tb_clock #(.PERIOD_NS(40)) tb_clock_i (.clk(clk));

    nete_tx #(
        .READ_LATENCY (READ_LATENCY)
    ) nete_tx_i (
        .clk          (clk),
        .reset_       (reset_),
        .tx_data_in   (tx_data_in),
        .tx_mac_empty (tx_mac_empty),
        .tx_mac_rd_en (tx_mac_rd_en),
        .tdata        (tdata),
        .tvalid       (tvalid),
        .tkeep        (tkeep),
        .tlast        (tlast)
    );

    bind nete_tx nete_tx_properties nete_tx_properties_i (
        .clk          (clk),
        .reset_       (reset_),
        .tx_mac_rd_en (tx_mac_rd_en),
        .tvalid       (tvalid),
        .tlast        (tlast),
        .tkeep        (tkeep)
    );

    function automatic logic [WORD_W-1:0] random_word();
        logic [WORD_W-1:0] w;
        for (int i = 0; i < WORD_W / 32; i++) begin
            w[32*i +: 32] = $urandom;
        end
        return w;
    endfunction

    // low n bits set
    function automatic logic [KEEP_W-1:0] keep_for_bytes(input int n);
        logic [KEEP_W-1:0] m;
        m = '0;
        for (int i = 0; i < n; i++) begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    function automatic lane_t bytes_under_keep(input logic [KEEP_W-1:0] keep);
        lane_t m;
        for (int i = 0; i < KEEP_W; i++) begin
            m[8*i +: 8] = keep[i] ? 8'hff : 8'h00;
        end
        return m;
    endfunction

    // one packet into the FIFO, its beats into the reference queues
    task automatic push_packet(input int tag, input int len);
        logic [7:0]        pkt_bytes[MAX_WORDS*WORD_BYTES];
        logic [WORD_W-1:0] w;
        lane_t             d;
        int                nwords;
        int                nbeats;
        int                base;
        nwords = (len + LANE_BYTES + WORD_BYTES - 1) / WORD_BYTES;
        nbeats = (len + LANE_BYTES - 1) / LANE_BYTES;
        for (int i = 0; i < nwords * WORD_BYTES; i++) begin
            pkt_bytes[i] = 8'($urandom_range(0, 255));
        end
        // header lane, byte count in bits 15:0
        pkt_bytes[0] = len[7:0];
        pkt_bytes[1] = len[15:8];
        for (int wi = 0; wi < nwords; wi++) begin
            for (int j = 0; j < WORD_BYTES; j++) begin
                w[8*j +: 8] = pkt_bytes[wi*WORD_BYTES + j];
            end
            fifo_q.push_back(w);
            tag_q.push_back(tag);
        end
        exp_reads[tag] = nwords;
        // payload starts right after the header lane
        for (int b = 0; b < nbeats; b++) begin
            base = LANE_BYTES + b * LANE_BYTES;
            for (int j = 0; j < LANE_BYTES; j++) begin
                d[8*j +: 8] = pkt_bytes[base + j];
            end
            exp_data_q.push_back(d);
            if (b == nbeats - 1) begin
                exp_keep_q.push_back(keep_for_bytes(len - b * LANE_BYTES));
                exp_last_q.push_back(1'b1);
            end else begin
                exp_keep_q.push_back({KEEP_W{1'b1}});
                exp_last_q.push_back(1'b0);
            end
        end
    endtask

    //**************************************************************************
    // FIFO model
    //**************************************************************************

    always @(posedge clk) begin
        data_due = 1'b0;
        if (rd_pending && rd_wait > 0) begin
            rd_wait = rd_wait - 1;
        end
        if (reset_ && tx_mac_rd_en === 1'b1) begin
            assert (fifo_q.size() != 0) else begin
                fifo_faults++;
                $display("read strobe at %0t with no word in the FIFO", $time);
            end
            if (fifo_q.size() != 0) begin
                pend_word = fifo_q.pop_front();
                pend_tag  = tag_q.pop_front();
                got_reads[pend_tag]++;
                rd_pending = 1'b1;
                rd_wait    = READ_LATENCY - 1;
            end
        end
        if (rd_pending && rd_wait == 0) begin
            data_due   = 1'b1;
            rd_pending = 1'b0;
        end
        #(DRIVE_DELAY);
        // garbage on the bus except in the cycle the word is due
        tx_data_in   = data_due ? pend_word : random_word();
        tx_mac_empty = (fifo_q.size() == 0);
    end

    //**************************************************************************
    // output checks, mid-cycle
    //**************************************************************************

    always @(negedge clk) begin
        if (!reset_) begin
            if (cycle_count > 0) begin
                assert (tvalid === 1'b0 && tlast === 1'b0 && tkeep === '0 &&
                        tx_mac_rd_en === 1'b0) else begin
                    out_faults++;
                    $display("outputs not low during reset at %0t", $time);
                end
            end
        end else if (tvalid === 1'b1) begin
            assert (exp_data_q.size() != 0) else begin
                out_faults++;
                $display("extra beat at %0t with no packet outstanding", $time);
            end
            if (exp_data_q.size() != 0) begin
                exp_data  = exp_data_q.pop_front();
                exp_keep  = exp_keep_q.pop_front();
                exp_last  = exp_last_q.pop_front();
                data_mask = bytes_under_keep(exp_keep);
                assert ((tdata & data_mask) === (exp_data & data_mask)) else begin
                    out_mismatches++;
                    $display("Mismatch at %0t: tdata %h, expected %h", $time, tdata, exp_data);
                end
                assert (tkeep === exp_keep) else begin
                    out_mismatches++;
                    $display("Mismatch at %0t: tkeep %b, expected %b", $time, tkeep, exp_keep);
                end
                assert (tlast === exp_last) else begin
                    out_mismatches++;
                    $display("Mismatch at %0t: tlast %b, expected %b", $time, tlast, exp_last);
                end
                if (exp_last) begin
                    pkts_seen++;
                end
            end
        end else if (idle_expected) begin
            // FIFO dry and stream drained
            assert (tlast === 1'b0 && tkeep === '0 && tx_mac_rd_en === 1'b0) else begin
                out_faults++;
                $display("activity at %0t while the FIFO is empty", $time);
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d packets delivered",
                     cycle_count, pkts_seen, NUM_PKTS);
            $display("Simulation failed");
            $finish;
        end
    end

    //**************************************************************************
    // stimulus and end of run
    //**************************************************************************

    initial begin
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        reset_ = 1'b1;
        // quiet FIFO right after reset
        idle_expected = 1'b1;
        repeat (8) @(negedge clk);
        idle_expected = 1'b0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            if (p < 5) begin
                nbytes = fixed_lens[p];
            end else begin
                nbytes = int'($urandom_range(1, MAX_PKT_BYTES));
            end
            if ($urandom_range(0, 3) == 0) begin
                // let everything drain, then hold the FIFO empty
                while (fifo_q.size() != 0 || exp_data_q.size() != 0) begin
                    @(negedge clk);
                end
                idle_expected = 1'b1;
                repeat ($urandom_range(1, 20)) @(negedge clk);
                idle_expected = 1'b0;
            end else begin
                @(negedge clk);
            end
            push_packet(p, nbytes);
        end
        while (pkts_seen < NUM_PKTS) begin
            @(negedge clk);
        end
        idle_expected = 1'b1;
        repeat (10) @(negedge clk);

        // reads per packet, ceil((bytes + 8) / 32)
        for (int p = 0; p < NUM_PKTS; p++) begin
            assert (got_reads[p] == exp_reads[p]) else begin
                end_mismatches++;
                $display("Mismatch at %0t: packet %0d took %0d reads, expected %0d",
                         $time, p, got_reads[p], exp_reads[p]);
            end
        end
        assert (exp_data_q.size() == 0 && fifo_q.size() == 0) else begin
            end_faults++;
            $display("packets left undelivered at the end of the run");
        end

        $display("errors: %0d mismatches, %0d other failures",
                 out_mismatches + end_mismatches, out_faults + fifo_faults + end_faults);
        if (out_mismatches + end_mismatches + out_faults + fifo_faults + end_faults == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/nete_pkg.sv
design/nete_fetch.sv
design/nete_beat_split.sv
design/nete_stream_out.sv
design/nete_tx.sv
test/tb_clock.sv
test/nete_tx_properties.sv
test/nete_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= nete_tx_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# build, run, and pass only when the pass line is in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
